/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
TOP       ?= tb_clint
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* axi_lite_pkg.sv */
package axi_lite_pkg;

    // AXI response codes; EXOKAY and DECERR are never produced here.
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    // read address channel payload.
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axi_ar_t;

    // write address channel payload.
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axi_aw_t;

    // write data channel payload.
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    // read data channel payload.
    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
    } axi_r_t;

    // write response channel payload.
    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

endpackage

/* clint_axi_slave.sv */
`timescale 1ns/10ps

module clint_axi_slave
    import axi_lite_pkg::*;
    import clint_pkg::*;
#(
    parameter logic [31:0] clint_mmio_base = 32'h0200_0000,
    parameter logic [31:0] clint_mmio_size = 32'h0001_0000
) (
    input  logic        aclk,
    input  logic        areset_n,

    input  logic        ar_valid,
    output logic        ar_ready,
    input  axi_ar_t     ar,

    output logic        r_valid,
    input  logic        r_ready,
    output axi_r_t      r,

    input  logic        aw_valid,
    output logic        aw_ready,
    input  axi_aw_t     aw,

    input  logic        w_valid,
    output logic        w_ready,
    input  axi_w_t      w,

    output logic        b_valid,
    input  logic        b_ready,
    output axi_b_t      b,

    input  logic [31:0] rdata,
    input  axi_resp_e   resp,
    output clint_req_t  req,
    output logic        in_window
);

    slave_state_e state;

    logic        ar_hs;
    logic        wr_hs;
    logic [31:0] req_addr;
    logic [31:0] rel_addr;

    assign ar_hs = ar_valid & ar_ready;
    assign wr_hs = aw_valid & aw_ready & w_valid & w_ready;

    // only one address channel is ready at a time, so its ready picks the address.
    assign req_addr = aw_ready ? aw.addr : ar.addr;
    assign rel_addr = req_addr - clint_mmio_base;

    assign in_window = (req_addr >= clint_mmio_base) && (rel_addr < clint_mmio_size);

    always_comb begin
        req.offset = {rel_addr[15:2], 2'b00};
        req.wdata  = w.data; // partial strobes write the whole word.
        req.write  = wr_hs;
        req.valid  = wr_hs | ar_hs;
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            state    <= st_idle;
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            r_valid  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_valid && w_valid) begin // writes win over a pending read.
                        aw_ready <= 1'b1;
                        w_ready  <= 1'b1;
                        state    <= st_addr;
                    end else if (ar_valid) begin
                        ar_ready <= 1'b1;
                        state    <= st_addr;
                    end
                end
                st_addr: begin
                    if (wr_hs) begin
                        aw_ready <= 1'b0;
                        w_ready  <= 1'b0;
                        b_valid  <= 1'b1;
                        state    <= st_resp_w;
                    end else if (ar_hs) begin
                        ar_ready <= 1'b0;
                        r_valid  <= 1'b1;
                        state    <= st_resp_r;
                    end
                end
                st_resp_r: begin
                    if (r_ready) begin
                        r_valid <= 1'b0;
                        state   <= st_idle;
                    end
                end
                st_resp_w: begin
                    if (b_ready) begin
                        b_valid <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // the register file answers in the handshake cycle, so capture it here.
    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            r.data <= rdata;
            r.resp <= resp;
        end else if (r_valid && r_ready) begin
            r <= '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_hs) begin
            b.resp <= resp;
        end else if (b_valid && b_ready) begin
            b <= '0;
        end
    end

endmodule

/* clint_pkg.sv */
package clint_pkg;

    // byte offsets from the CLINT base for hart 0.
    localparam logic [15:0] msip_off        = 16'h0000;
    localparam logic [15:0] mtimecmp_lo_off = 16'h4000;
    localparam logic [15:0] mtimecmp_hi_off = 16'h4004;
    localparam logic [15:0] mtime_lo_off    = 16'hBFF8;
    localparam logic [15:0] mtime_hi_off    = 16'hBFFC;

    typedef enum logic [2:0] {
        reg_msip,
        reg_mtimecmp_lo,
        reg_mtimecmp_hi,
        reg_mtime_lo,
        reg_mtime_hi,
        reg_none
    } clint_reg_e;

    // one request from the bus front end, valid for a single cycle.
    typedef struct packed {
        logic [15:0] offset;
        logic [31:0] wdata;
        logic        write;
        logic        valid;
    } clint_req_t;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_resp_r,
        st_resp_w
    } slave_state_e;

endpackage

/* clint_regfile.sv */
`timescale 1ns/10ps

module clint_regfile
    import axi_lite_pkg::*;
    import clint_pkg::*;
(
    input  logic        aclk,
    input  logic        areset_n,
    input  clint_req_t  req,
    input  logic        in_window,
    input  logic [63:0] mtime,
    output logic [31:0] rdata,
    output axi_resp_e   resp,
    output logic        msip,
    output logic [63:0] mtimecmp,
    output logic        mtime_we_lo,
    output logic        mtime_we_hi,
    output logic [31:0] mtime_wdata
);

    clint_reg_e sel;
    logic       wr_en;

    always_comb begin
        if (!in_window) begin
            sel = reg_none;
        end else begin
            case (req.offset)
                msip_off:        sel = reg_msip;
                mtimecmp_lo_off: sel = reg_mtimecmp_lo;
                mtimecmp_hi_off: sel = reg_mtimecmp_hi;
                mtime_lo_off:    sel = reg_mtime_lo;
                mtime_hi_off:    sel = reg_mtime_hi;
                default:         sel = reg_none;
            endcase
        end
    end

    assign wr_en = req.valid & req.write;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            msip     <= 1'b0;
            mtimecmp <= 64'd0;
        end else if (wr_en) begin
            case (sel)
                reg_msip:        msip            <= req.wdata[0];
                reg_mtimecmp_lo: mtimecmp[31:0]  <= req.wdata;
                reg_mtimecmp_hi: mtimecmp[63:32] <= req.wdata;
                default: ;
            endcase
        end
    end

    // the counter itself lives in the timer, so mtime writes become enables.
    assign mtime_we_lo = wr_en & (sel == reg_mtime_lo);
    assign mtime_we_hi = wr_en & (sel == reg_mtime_hi);
    assign mtime_wdata = req.wdata;

    always_comb begin
        resp = resp_okay;
        case (sel)
            reg_msip:        rdata = {31'd0, msip};
            reg_mtimecmp_lo: rdata = mtimecmp[31:0];
            reg_mtimecmp_hi: rdata = mtimecmp[63:32];
            reg_mtime_lo:    rdata = mtime[31:0];
            reg_mtime_hi:    rdata = mtime[63:32];
            default: begin
                rdata = 32'd0;
                resp  = resp_slverr; // outside the window or an unmapped word.
            end
        endcase
    end

endmodule

/* clint_timer.sv */
`timescale 1ns/10ps

module clint_timer #(
    parameter int tick_div = 4
) (
    input  logic        aclk,
    input  logic        areset_n,
    input  logic        mtime_we_lo,
    input  logic        mtime_we_hi,
    input  logic [31:0] mtime_wdata,
    input  logic [63:0] mtimecmp,
    output logic [63:0] mtime,
    output logic        mtip
);

    localparam int div_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [div_w-1:0] div_cnt;
    logic             tick;

    assign tick = (div_cnt == div_w'(tick_div - 1));

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // a software write wins over the tick that lands in the same cycle.
    always_ff @(posedge aclk) begin
        if (areset_n) begin
            mtime <= 64'd0;
        end else if (mtime_we_lo) begin
            mtime[31:0] <= mtime_wdata;
        end else if (mtime_we_hi) begin
            mtime[63:32] <= mtime_wdata;
        end else if (tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime >= mtimecmp); // follows the compare one cycle late.
        end
    end

endmodule

/* clint_top.sv */
`timescale 1ns/10ps

module clint_top
    import axi_lite_pkg::*;
    import clint_pkg::*;
#(
    parameter logic [31:0] clint_mmio_base = 32'h0200_0000,
    parameter logic [31:0] clint_mmio_size = 32'h0001_0000,
    parameter int          tick_div        = 4
) (
    input  logic    aclk,
    input  logic    areset_n,

    input  logic    ar_valid,
    output logic    ar_ready,
    input  axi_ar_t ar,

    output logic    r_valid,
    input  logic    r_ready,
    output axi_r_t  r,

    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_aw_t aw,

    input  logic    w_valid,
    output logic    w_ready,
    input  axi_w_t  w,

    output logic    b_valid,
    input  logic    b_ready,
    output axi_b_t  b,

    output logic    mtip,
    output logic    msip
);

    clint_req_t  req;
    logic        in_window;
    logic [31:0] rdata;
    axi_resp_e   resp;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        mtime_we_lo;
    logic        mtime_we_hi;
    logic [31:0] mtime_wdata;

    clint_axi_slave #(
        .clint_mmio_base (clint_mmio_base),
        .clint_mmio_size (clint_mmio_size)
    ) slave0 (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b         (b),
        .rdata     (rdata),
        .resp      (resp),
        .req       (req),
        .in_window (in_window)
    );

    clint_regfile regfile0 (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .req         (req),
        .in_window   (in_window),
        .mtime       (mtime),
        .rdata       (rdata),
        .resp        (resp),
        .msip        (msip),
        .mtimecmp    (mtimecmp),
        .mtime_we_lo (mtime_we_lo),
        .mtime_we_hi (mtime_we_hi),
        .mtime_wdata (mtime_wdata)
    );

    clint_timer #(
        .tick_div (tick_div)
    ) timer0 (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .mtime_we_lo (mtime_we_lo),
        .mtime_we_hi (mtime_we_hi),
        .mtime_wdata (mtime_wdata),
        .mtimecmp    (mtimecmp),
        .mtime       (mtime),
        .mtip        (mtip)
    );

endmodule

/* clint_trace.txt */
# op      name          addr     data     resp   margin
# data is the write data, the expected read data or {mtip,msip}; resp - is not checked
wr      cmp_lo_wr     02004000 89abcdef okay   0
wr      cmp_hi_wr     02004004 01234567 okay   0
rd      cmp_lo_rd     02004000 89abcdef okay   0
rd      cmp_hi_rd     02004004 01234567 okay   0
wr      msip_set      02000000 00000001 okay   0
rd      msip_rd_one   02000000 00000001 okay   0
chk_irq msip_high     00000000 00000001 -      0
wr      msip_clr      02000000 00000000 okay   0
rd      msip_rd_zero  02000000 00000000 okay   0
chk_irq msip_low      00000000 00000000 -      0
wr      mtime_hi_wr   0200bffc 00000000 okay   0
wr      mtime_lo_wr   0200bff8 00000100 okay   0
rdge    mtime_rd_a    0200bff8 00000100 okay   20
rdge    mtime_rd_b    0200bff8 00000100 okay   20
rd      mtime_hi_rd   0200bffc 00000000 okay   0
wr      mtime_lo_100  0200bff8 00000064 okay   0
wr      cmp_hi_zero   02004004 00000000 okay   0
wr      cmp_lo_100    02004000 00000064 okay   0
chk_irq timer_high    00000000 00000002 -      0
wr      cmp_hi_far    02004004 00000001 okay   0
chk_irq timer_low     00000000 00000000 -      0
wr      gap_wr        02000008 deadbeef slverr 0
rd      gap_rd        02000008 00000000 slverr 0
rd      gap_rd_high   0200bff0 00000000 slverr 0
rd      outside_rd    02010000 00000000 slverr 0
rd      cmp_lo_keep   02004000 00000064 okay   0
rd      cmp_hi_keep   02004004 00000001 okay   0
rd      msip_keep     02000000 00000000 okay   0

/* files.f */
axi_lite_pkg.sv
clint_pkg.sv
clint_axi_slave.sv
clint_regfile.sv
clint_timer.sv
clint_top.sv
tb_clint_asserts.sv
tb_clint.sv

/* tb_clint.sv */
`timescale 1ns/10ps

module tb_clint
    import axi_lite_pkg::*;
();

    localparam int timeout_cycles = 50;

    logic    aclk;
    logic    areset_n;
    logic    ar_valid;
    logic    ar_ready;
    axi_ar_t ar;
    logic    r_valid;
    logic    r_ready;
    axi_r_t  r;
    logic    aw_valid;
    logic    aw_ready;
    axi_aw_t aw;
    logic    w_valid;
    logic    w_ready;
    axi_w_t  w;
    logic    b_valid;
    logic    b_ready;
    axi_b_t  b;
    logic    mtip;
    logic    msip;

    int   seed;
    int   r_beats; // read responses raised on the bus.
    int   reads_issued;
    logic r_valid_q;

    clint_top #(
        .tick_div (4)
    ) dut0 (
        .aclk     (aclk),
        .areset_n (areset_n),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .mtip     (mtip),
        .msip     (msip)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        if (areset_n) begin
            r_beats   <= 0;
            r_valid_q <= 1'b0;
        end else begin
            r_valid_q <= r_valid;
            if (r_valid && !r_valid_q) begin
                r_beats <= r_beats + 1;
            end
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_run($sformatf("mismatch %s expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    // lo is inclusive and hi is exclusive.
    task automatic check_range(input string name, input logic [31:0] lo, input logic [31:0] hi,
                               input logic [31:0] act);
        if (act < lo || act >= hi) begin
            stop_run($sformatf("mismatch %s expected 0x%08h to 0x%08h actual 0x%08h",
                               name, lo, hi - 32'd1, act));
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
        if (act !== exp) begin
            stop_run($sformatf("mismatch %s expected %s actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_irq(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic axi_read(input string name, input logic [31:0] addr,
                            output logic [31:0] data, output axi_resp_e resp);
        int     waited;
        int     stall;
        axi_r_t held;
        @(posedge aclk);
        #1;
        ar.addr  = addr;
        ar.prot  = 3'b000;
        ar_valid = 1'b1;
        waited   = 0;
        while (!ar_ready) begin
            waited++;
            if (waited > timeout_cycles) begin
                stop_run($sformatf("timeout waiting for ar_ready in %s", name));
            end
            @(posedge aclk);
            #1;
        end
        @(posedge aclk); // ar handshake.
        #1;
        ar_valid = 1'b0;
        waited   = 0;
        while (!r_valid) begin
            waited++;
            if (waited > timeout_cycles) begin
                stop_run($sformatf("timeout waiting for r_valid in %s", name));
            end
            @(posedge aclk);
            #1;
        end
        held  = r;
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) begin
            @(posedge aclk);
            #1;
            if (!r_valid || r !== held) begin
                stop_run($sformatf("read response of %s changed before r_ready", name));
            end
        end
        r_ready = 1'b1;
        @(posedge aclk); // r handshake.
        #1;
        r_ready = 1'b0;
        if (r_valid) begin
            stop_run($sformatf("r_valid still high after the response of %s was taken", name));
        end
        data = held.data;
        resp = held.resp;
        reads_issued++;
    endtask

    task automatic axi_write(input string name, input logic [31:0] addr,
                             input logic [31:0] data, output axi_resp_e resp);
        int waited;
        @(posedge aclk);
        #1;
        aw.addr  = addr;
        aw.prot  = 3'b000;
        w.data   = data;
        w.strb   = 4'hf;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        waited   = 0;
        while (!(aw_ready && w_ready)) begin
            waited++;
            if (waited > timeout_cycles) begin
                stop_run($sformatf("timeout waiting for aw_ready and w_ready in %s", name));
            end
            @(posedge aclk);
            #1;
        end
        @(posedge aclk); // aw and w handshake.
        #1;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        waited   = 0;
        while (!b_valid) begin
            waited++;
            if (waited > timeout_cycles) begin
                stop_run($sformatf("timeout waiting for b_valid in %s", name));
            end
            @(posedge aclk);
            #1;
        end
        resp    = b.resp;
        b_ready = 1'b1;
        @(posedge aclk);
        #1;
        b_ready = 1'b0;
        if (b_valid) begin
            stop_run($sformatf("b_valid still high after the response of %s was taken", name));
        end
    endtask

    initial begin
        int               fd;
        int               code;
        logic [8*8-1:0]   op_raw;
        logic [8*24-1:0]  name_raw;
        logic [8*8-1:0]   resp_raw;
        logic [8*128-1:0] line;
        logic [31:0]      addr;
        logic [31:0]      value;
        logic [31:0]      margin;
        logic [31:0]      got_data;
        logic [31:0]      last_rdge;
        logic [31:0]      lo;
        axi_resp_e        got_resp;
        axi_resp_e        exp_resp;
        string            op;
        string            name;
        string            resp_s;
        areset_n  = 1'b1;
        ar_valid  = 1'b0;
        ar        = '0;
        r_ready   = 1'b0;
        aw_valid  = 1'b0;
        aw        = '0;
        w_valid   = 1'b0;
        w         = '0;
        b_ready   = 1'b0;
        seed      = 61;
        last_rdge = 32'd0;
        repeat (2) @(posedge aclk);
        #1;
        areset_n = 1'b0;
        fd = $fopen("clint_trace.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open clint_trace.txt for reading");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op_raw);
            if (code != 1) begin
                break;
            end
            op = $sformatf("%0s", op_raw);
            if (op == "#") begin
                code = $fgets(line, fd); // rest of a comment line.
                continue;
            end
            code = $fscanf(fd, "%s %h %h %s %h", name_raw, addr, value, resp_raw, margin);
            if (code != 5) begin
                stop_run($sformatf("malformed trace line for operation %s", op));
            end
            name   = $sformatf("%0s", name_raw);
            resp_s = $sformatf("%0s", resp_raw);
            if (resp_s != "okay" && resp_s != "slverr" && resp_s != "-") begin
                stop_run($sformatf("unknown response %s in trace line %s", resp_s, name));
            end
            exp_resp = (resp_s == "slverr") ? resp_slverr : resp_okay;
            if (op == "wr") begin
                axi_write(name, addr, value, got_resp);
                check_resp(name, exp_resp, got_resp);
                last_rdge = 32'd0; // a write may move mtime backwards.
            end else if (op == "rd") begin
                axi_read(name, addr, got_data, got_resp);
                check_data(name, value, got_data);
                check_resp(name, exp_resp, got_resp);
            end else if (op == "rdge") begin
                axi_read(name, addr, got_data, got_resp);
                lo = (last_rdge > value) ? last_rdge : value;
                check_range(name, lo, value + margin, got_data);
                check_resp(name, exp_resp, got_resp);
                last_rdge = got_data;
            end else if (op == "chk_irq") begin
                check_irq(name, value[1:0], {mtip, msip});
            end else begin
                stop_run($sformatf("unknown operation %s in trace line %s", op, name));
            end
        end
        $fclose(fd);
        check_data("read_count", reads_issued, r_beats);
        if (dut0.slave0.asserts0.failures == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_run("an assertion on the AXI handshake failed during the run");
        end
    end

endmodule

/* tb_clint_asserts.sv */
`timescale 1ns/10ps

module tb_clint_asserts
    import axi_lite_pkg::*;
(
    input logic   aclk,
    input logic   areset_n,
    input logic   ar_ready,
    input logic   r_valid,
    input logic   r_ready,
    input axi_r_t r,
    input logic   b_valid,
    input logic   b_ready,
    input axi_b_t b
);

    int failures; // the testbench reads this at the end of the run.

    r_hold: assert property (@(posedge aclk) disable iff (areset_n)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else begin
            $error("read response dropped or changed before r_ready");
            failures++;
        end

    b_hold: assert property (@(posedge aclk) disable iff (areset_n)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else begin
            $error("write response dropped or changed before b_ready");
            failures++;
        end

    // a new read address must wait until the pending response is taken.
    no_ar_while_busy: assert property (@(posedge aclk) disable iff (areset_n)
        !(ar_ready && (r_valid || b_valid)))
        else begin
            $error("ar_ready high while a response is pending");
            failures++;
        end

endmodule

bind clint_axi_slave tb_clint_asserts asserts0 (
    .aclk     (aclk),
    .areset_n (areset_n),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b)
);
